// ==== list.f ====
rtl/bus_map_pkg.sv
rtl/controller_pkg.sv
rtl/controller_link_if.sv
rtl/address_decoder.sv
rtl/fetch_sequencer.sv
rtl/controller_receiver.sv
rtl/button_readback.sv
rtl/console_io_top.sv
verif/tb_console_io.sv

// ==== verif/tb_console_io.sv ====
`timescale 1ns/10ps

module tb_console_io;

    localparam int NUM_CONTROLLERS = 2;
    localparam int HALF_PERIOD     = 4;
    localparam int CLK_PERIOD      = 8;
    localparam int POLL_CYCLES     = 18 * HALF_PERIOD;
    localparam int NUM_POLLS       = 3;

    logic                         cpu_clk;
    logic                         rst;
    logic [15:0]                  cpu_address;
    logic                         write_enable;
    logic [7:0]                   data_out;
    logic                         fpga_data_enable;
    logic                         select_ram_b;
    logic                         select_rom_b;
    logic                         poll_irq_b;
    logic                         controller_latch;
    logic                         controller_clk;
    logic [NUM_CONTROLLERS-1:0]   controller_data_in_b;
    logic [NUM_CONTROLLERS*8-1:0] controller_buttons_out;

    controller_pkg::buttons_t next_bytes   [NUM_CONTROLLERS]; // what the pads hold for the next latch
    controller_pkg::buttons_t loaded_bytes [NUM_CONTROLLERS];
    controller_pkg::buttons_t pad_shift    [NUM_CONTROLLERS];
    logic [31:0] lfsr;
    logic        exp_irq;
    logic        exp_busy;
    int          errors;
    int          clk_edges;
    int          latch_rises;

    logic [15:0] sweep_addrs [17] = '{16'h0000, 16'h1234, 16'h3FFF, 16'h4000, 16'h40FF,
                                      16'h4100, 16'h4101, 16'h4102, 16'h410F, 16'h4110,
                                      16'h4111, 16'h4112, 16'h4113, 16'h7FFF, 16'h8000,
                                      16'hC000, 16'hFFFF};

    console_io_top #(
        .NUM_CONTROLLERS(NUM_CONTROLLERS),
        .HALF_PERIOD    (HALF_PERIOD)
    ) u_dut (.*);

    initial begin
        cpu_clk = 1'b0;
        forever #(CLK_PERIOD / 2) cpu_clk = ~cpu_clk;
    end

    // ##################################################
    // controller pad models
    // ##################################################

    always @(posedge controller_latch) begin
        latch_rises++;
        for (int i = 0; i < NUM_CONTROLLERS; i++) begin
            pad_shift[i]    = next_bytes[i];
            loaded_bytes[i] = next_bytes[i];
        end
    end

    always @(posedge controller_clk) begin
        clk_edges++;
        for (int i = 0; i < NUM_CONTROLLERS; i++) begin
            pad_shift[i] = {1'b0, pad_shift[i][7:1]}; // released buttons fill in behind
        end
    end

    for (genvar i = 0; i < NUM_CONTROLLERS; i++) begin : g_pad
        assign controller_data_in_b[i] = ~pad_shift[i][0]; // pressed pulls the wire low
    end

    always @(negedge cpu_clk) begin
        if (!rst && controller_latch && controller_clk) begin
            errors++;
            $display("[FAIL] %0t: latch and controller clock high together", $time);
        end
    end

    // ##################################################
    // reference model and compare tasks
    // ##################################################

    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]}; // taps 32 22 2 1
    endfunction

    function automatic logic [7:0] expected_read(input logic [15:0] addr);
        logic [7:0] v;
        v = '0;
        if (addr >= bus_map_pkg::CONTROLLER_BASE &&
            addr < bus_map_pkg::CONTROLLER_BASE + NUM_CONTROLLERS) begin
            v = loaded_bytes[addr - bus_map_pkg::CONTROLLER_BASE];
        end else if (addr == bus_map_pkg::STATUS_ADDR) begin
            v[controller_pkg::STATUS_IRQ_BIT]  = exp_irq;
            v[controller_pkg::STATUS_BUSY_BIT] = exp_busy;
        end
        return v;
    endfunction

    task automatic check_byte(input controller_pkg::buttons_t got, exp, input string what);
        if (got !== exp) begin
            errors++;
            $display("[FAIL] %0t: %s got %h expected %h", $time, what, got, exp);
        end
    endtask

    task automatic check_status(input logic [7:0] got, exp, input string what);
        if (got !== exp) begin
            errors++;
            $display("[FAIL] %0t: %s got %b expected %b", $time, what, got, exp);
        end
    endtask

    // pins are ram_b, rom_b and the data enable
    task automatic check_select(input logic [2:0] got, exp, input string what);
        if (got !== exp) begin
            errors++;
            $display("[FAIL] %0t: %s pins got %b expected %b", $time, what, got, exp);
        end
    endtask

    task automatic check_count(input int got, exp, input string what);
        if (got != exp) begin
            errors++;
            $display("[FAIL] %0t: %s got %0d expected %0d", $time, what, got, exp);
        end
    endtask

    // ##################################################
    // cpu bus tasks
    // ##################################################

    task automatic next_cycle;
        @(posedge cpu_clk);
        #1;
    endtask

    task automatic cpu_write(input logic [15:0] addr);
        cpu_address  = addr;
        write_enable = 1'b1;
        next_cycle(); // the write takes effect on this edge
        write_enable = 1'b0;
    endtask

    task automatic read_check(input logic [15:0] addr);
        logic       ctrl;
        logic [2:0] exp_pins;
        ctrl = (addr >= bus_map_pkg::CONTROLLER_BASE) &&
               (addr < bus_map_pkg::CONTROLLER_BASE + NUM_CONTROLLERS);
        exp_pins = {!(addr <= bus_map_pkg::RAM_LAST), !(addr >= bus_map_pkg::ROM_BASE),
                    ctrl || (addr == bus_map_pkg::STATUS_ADDR)};
        cpu_address  = addr;
        write_enable = 1'b0;
        #2;
        check_select({select_ram_b, select_rom_b, fpga_data_enable}, exp_pins,
                     $sformatf("read of %h", addr));
        if (ctrl) begin
            check_byte(data_out, expected_read(addr), $sformatf("controller at %h", addr));
        end else begin
            check_status(data_out, expected_read(addr), $sformatf("read of %h", addr));
        end
        next_cycle();
    endtask

    task automatic run_poll(input bit second_fetch);
        int cycles;
        for (int i = 0; i < NUM_CONTROLLERS; i++) begin
            for (int b = 0; b < 8; b++) begin
                lfsr             = lfsr_step(lfsr);
                next_bytes[i][b] = lfsr[0];
            end
        end
        clk_edges   = 0;
        latch_rises = 0;
        cpu_write(bus_map_pkg::FETCH_ADDR);
        exp_busy = 1'b1;
        cycles   = 0;
        while (poll_irq_b && cycles < 4 * POLL_CYCLES) begin
            if (second_fetch && cycles == 20) begin
                cpu_address  = bus_map_pkg::FETCH_ADDR;
                write_enable = 1'b1; // lands in the middle of the poll
            end
            if (cycles == 10) begin
                read_check(bus_map_pkg::STATUS_ADDR);
            end else begin
                next_cycle();
            end
            write_enable = 1'b0;
            cycles++;
        end
        if (poll_irq_b) begin
            errors++;
            $display("poll interrupt never came after the fetch write");
        end
        exp_busy = 1'b0;
        exp_irq  = 1'b1;
        check_count(cycles, POLL_CYCLES + 1, "cycles from fetch to irq");
        check_count(clk_edges, controller_pkg::BUTTON_COUNT, "controller clock edges");
        repeat (20) next_cycle(); // a stray second poll would show a new latch here
        check_count(latch_rises, 1, "latch pulses");
        read_check(bus_map_pkg::STATUS_ADDR);
        for (int i = 0; i < NUM_CONTROLLERS; i++) begin
            read_check(bus_map_pkg::CONTROLLER_BASE + 16'(i));
            check_byte(controller_buttons_out[i*8 +: 8], loaded_bytes[i], "buttons_out");
        end
    endtask

    task automatic clear_irq;
        cpu_write(bus_map_pkg::IRQ_CLEAR_ADDR);
        exp_irq = 1'b0;
        check_count(poll_irq_b, 1, "poll_irq_b after clear");
        read_check(bus_map_pkg::STATUS_ADDR);
        for (int i = 0; i < NUM_CONTROLLERS; i++) begin
            read_check(bus_map_pkg::CONTROLLER_BASE + 16'(i)); // snapshots survive the clear
        end
    endtask

    // ##################################################
    // main sequence and watchdog
    // ##################################################

    initial begin
        rst          = 1'b1;
        cpu_address  = '0;
        write_enable = 1'b0;
        lfsr         = 32'h795c5989;
        exp_irq      = 1'b0;
        exp_busy     = 1'b0;
        errors       = 0;
        clk_edges    = 0;
        latch_rises  = 0;
        for (int i = 0; i < NUM_CONTROLLERS; i++) begin
            next_bytes[i]   = '0;
            loaded_bytes[i] = '0;
            pad_shift[i]    = '0;
        end
        repeat (5) @(posedge cpu_clk);
        #1;
        rst = 1'b0;

        foreach (sweep_addrs[k]) begin
            read_check(sweep_addrs[k]);
        end

        run_poll(1'b0);
        clear_irq();
        run_poll(1'b1); // the extra fetch mid poll has to be dropped
        clear_irq();
        run_poll(1'b0);

        $display("checks complete, %0d errors", errors);
        if (errors == 0) begin
            $display("Finished with no errors");
        end else begin
            $display("Finished with errors");
        end
        $finish;
    end

    initial begin
        #((NUM_POLLS + 4) * POLL_CYCLES * CLK_PERIOD + 2000);
        $display("timeout: the test sequence did not finish in the expected time");
        $display("Finished with errors");
        $finish;
    end

endmodule

// ==== rtl/console_io_top.sv ====
`timescale 1ns/10ps

module console_io_top #(
    parameter int NUM_CONTROLLERS = 2,
    parameter int HALF_PERIOD     = 4
) (
    input  logic                         cpu_clk,
    input  logic                         rst,

    input  logic [15:0]                  cpu_address,
    input  logic                         write_enable,
    output logic [7:0]                   data_out,
    output logic                         fpga_data_enable,

    output logic                         select_ram_b,
    output logic                         select_rom_b,
    output logic                         poll_irq_b,

    output logic                         controller_latch,
    output logic                         controller_clk,
    input  logic [NUM_CONTROLLERS-1:0]   controller_data_in_b,
    output logic [NUM_CONTROLLERS*8-1:0] controller_buttons_out
);

    bus_map_pkg::bus_select_t                       select;
    controller_pkg::buttons_t [NUM_CONTROLLERS-1:0] live_buttons; // bytes still being shifted
    logic                                           fetch_start;
    logic                                           busy;
    logic                                           poll_irq;

    controller_link_if link ();

    assign controller_latch = link.latch;
    assign controller_clk   = link.serial_clk;
    assign poll_irq_b       = ~poll_irq;

    address_decoder #(
        .NUM_CONTROLLERS(NUM_CONTROLLERS)
    ) u_address_decoder (
        .cpu_address (cpu_address),
        .select      (select),
        .select_ram_b(select_ram_b),
        .select_rom_b(select_rom_b)
    );

    fetch_sequencer #(
        .HALF_PERIOD(HALF_PERIOD)
    ) u_fetch_sequencer (
        .cpu_clk(cpu_clk),
        .rst    (rst),
        .start  (fetch_start),
        .busy   (busy),
        .link   (link)
    );

    // ##################################################
    // one receiver per pad
    // ##################################################

    for (genvar i = 0; i < NUM_CONTROLLERS; i++) begin : g_receiver
        controller_receiver u_controller_receiver (
            .cpu_clk  (cpu_clk),
            .rst      (rst),
            .data_in_b(controller_data_in_b[i]),
            .link     (link),
            .buttons  (live_buttons[i])
        );
    end

    button_readback #(
        .NUM_CONTROLLERS(NUM_CONTROLLERS)
    ) u_button_readback (
        .cpu_clk         (cpu_clk),
        .rst             (rst),
        .select          (select),
        .write_enable    (write_enable),
        .buttons         (live_buttons),
        .busy            (busy),
        .link            (link),
        .fetch_start     (fetch_start),
        .irq             (poll_irq),
        .data_out        (data_out),
        .fpga_data_enable(fpga_data_enable),
        .buttons_out     (controller_buttons_out)
    );

endmodule

// ==== rtl/button_readback.sv ====
`timescale 1ns/10ps

module button_readback #(
    parameter int NUM_CONTROLLERS = 2
) (
    input  logic                                        cpu_clk,
    input  logic                                        rst,
    input  bus_map_pkg::bus_select_t                    select,
    input  logic                                        write_enable,
    input  controller_pkg::buttons_t [NUM_CONTROLLERS-1:0] buttons,
    input  logic                                        busy,
    controller_link_if.readback                         link,
    output logic                                        fetch_start,
    output logic                                        irq,
    output logic [7:0]                                  data_out,
    output logic                                        fpga_data_enable,
    output controller_pkg::buttons_t [NUM_CONTROLLERS-1:0] buttons_out
);

    controller_pkg::buttons_t [NUM_CONTROLLERS-1:0] snapshot;
    logic [7:0] status_byte;
    logic       cpu_read;

    assign cpu_read = !write_enable;

    // a fetch during a poll just falls on the floor
    assign fetch_start = write_enable && select.fetch && !busy;

    // ##################################################
    // snapshot and interrupt
    // ##################################################

    always_ff @(posedge cpu_clk) begin
        if (rst) begin
            snapshot <= '0;
            irq      <= 1'b0;
        end else if (link.done) begin
            snapshot <= buttons; // all pads in one go
            irq      <= 1'b1;    // done beats a clear on the same cycle
        end else if (write_enable && select.irq_clear) begin
            irq <= 1'b0;
        end
    end

    always_comb begin
        status_byte = '0;
        status_byte[controller_pkg::STATUS_IRQ_BIT]  = irq;
        status_byte[controller_pkg::STATUS_BUSY_BIT] = busy;
    end

    // ##################################################
    // cpu read mux
    // ##################################################

    always_comb begin
        data_out = '0;
        if (cpu_read && select.controller) begin
            data_out = snapshot[select.controller_index]; // decoder keeps the index in range
        end else if (cpu_read && select.status) begin
            data_out = status_byte;
        end
    end

    assign fpga_data_enable = cpu_read && (select.controller || select.status);
    assign buttons_out      = snapshot;

    irq_follows_done: assert property (@(posedge cpu_clk) disable iff (rst)
        $rose(irq) |-> $past(link.done));

endmodule

// ==== rtl/controller_receiver.sv ====
`timescale 1ns/10ps

module controller_receiver (
    input  logic                  cpu_clk,
    input  logic                  rst,
    input  logic                  data_in_b,
    controller_link_if.receiver   link,
    output controller_pkg::buttons_t buttons
);

    controller_pkg::buttons_t shift_q;

    // bits enter at the top and walk down, so the first one ends up in bit 0
    always_ff @(posedge cpu_clk) begin
        if (rst) begin
            shift_q <= '0;
        end else if (link.sample) begin
            if (link.latch) begin
                shift_q <= {~data_in_b, 7'b0}; // first bit of a new byte
            end else begin
                shift_q <= {~data_in_b, shift_q[7:1]};
            end
        end
    end

    assign buttons = shift_q;

    // the latch window holds exactly one sample
    one_latch_sample: assert property (@(posedge cpu_clk) disable iff (rst)
        (link.sample && link.latch) |=> (!link.sample until !link.latch));

endmodule

// ==== rtl/fetch_sequencer.sv ====
`timescale 1ns/10ps

module fetch_sequencer #(
    parameter int HALF_PERIOD = 4
) (
    input  logic cpu_clk,
    input  logic rst,
    input  logic start,
    output logic busy,
    controller_link_if.sequencer link
);

    localparam int CNT_W = $clog2(2 * HALF_PERIOD);
    localparam int BIT_W = $clog2(controller_pkg::BUTTON_COUNT);

    localparam logic [CNT_W-1:0] LATCH_LAST = CNT_W'(2 * HALF_PERIOD - 1);
    localparam logic [CNT_W-1:0] HALF_LAST  = CNT_W'(HALF_PERIOD - 1);
    localparam logic [BIT_W-1:0] BIT_LAST   = BIT_W'(controller_pkg::BUTTON_COUNT - 1);

    typedef enum logic [1:0] {
        st_idle,
        st_latch,
        st_low,
        st_high
    } state_t;

    state_t           state;
    logic [CNT_W-1:0] cnt;     // cycles spent in the current phase
    logic [BIT_W-1:0] bit_cnt; // which serial slot we are in
    logic             done_q;

    // ##################################################
    // poll state machine
    // ##################################################

    always_ff @(posedge cpu_clk) begin
        if (rst) begin
            state   <= st_idle;
            cnt     <= '0;
            bit_cnt <= '0;
            done_q  <= 1'b0;
        end else begin
            done_q <= 1'b0;
            case (state)
                st_idle: begin
                    if (start) begin
                        state   <= st_latch;
                        cnt     <= '0;
                        bit_cnt <= '0;
                    end
                end
                st_latch: begin
                    if (cnt == LATCH_LAST) begin
                        state <= st_low;
                        cnt   <= '0;
                    end else begin
                        cnt <= cnt + 1'b1;
                    end
                end
                st_low: begin
                    if (cnt == HALF_LAST) begin
                        state <= st_high; // rising edge, pad moves to its next bit
                        cnt   <= '0;
                    end else begin
                        cnt <= cnt + 1'b1;
                    end
                end
                default: begin
                    if (cnt == HALF_LAST) begin
                        cnt <= '0;
                        if (bit_cnt == BIT_LAST) begin
                            state  <= st_idle;
                            done_q <= 1'b1;
                        end else begin
                            state   <= st_low;
                            bit_cnt <= bit_cnt + 1'b1;
                        end
                    end else begin
                        cnt <= cnt + 1'b1;
                    end
                end
            endcase
        end
    end

    assign link.latch      = (state == st_latch);
    assign link.serial_clk = (state == st_high);
    assign link.done       = done_q;

    // bit 0 is taken at the end of latch, the rest at the end of each high phase
    // except the last one, which has no fresh bit behind it
    assign link.sample = ((state == st_latch) && (cnt == LATCH_LAST)) ||
                         ((state == st_high) && (cnt == HALF_LAST) && (bit_cnt != BIT_LAST));

    assign busy = (state != st_idle) || done_q; // held through done so irq and busy swap together

    latch_clk_exclusive: assert property (@(posedge cpu_clk) disable iff (rst)
        !(link.latch && link.serial_clk));

    sample_done_exclusive: assert property (@(posedge cpu_clk) disable iff (rst)
        !(link.sample && link.done));

endmodule

// ==== rtl/address_decoder.sv ====
`timescale 1ns/10ps

module address_decoder #(
    parameter int NUM_CONTROLLERS = 2
) (
    input  logic [15:0]              cpu_address,
    output bus_map_pkg::bus_select_t select,
    output logic                     select_ram_b,
    output logic                     select_rom_b
);

    logic [15:0] controller_offset;

    // addresses below the base wrap to large values and drop out of the range check
    assign controller_offset = cpu_address - bus_map_pkg::CONTROLLER_BASE;

    always_comb begin
        select = '0;

        select.ram = (cpu_address >= bus_map_pkg::RAM_BASE) &&
                     (cpu_address <= bus_map_pkg::RAM_LAST);
        select.rom = (cpu_address >= bus_map_pkg::ROM_BASE);

        // only pads that exist get a select, the readback trusts this
        select.controller       = (controller_offset < 16'(NUM_CONTROLLERS));
        select.controller_index = controller_offset[3:0];

        select.status    = (cpu_address == bus_map_pkg::STATUS_ADDR);
        select.fetch     = (cpu_address == bus_map_pkg::FETCH_ADDR);
        select.irq_clear = (cpu_address == bus_map_pkg::IRQ_CLEAR_ADDR);
    end

    assign select_ram_b = ~select.ram;
    assign select_rom_b = ~select.rom;

endmodule

// ==== rtl/controller_link_if.sv ====
`timescale 1ns/10ps

interface controller_link_if;

    logic latch;      // goes straight to the pad latch pin
    logic serial_clk; // goes straight to the pad clock pin
    logic sample;     // receivers take one bit on this strobe
    logic done;       // last bit is in, poll is over

    modport sequencer (
        output latch,
        output serial_clk,
        output sample,
        output done
    );

    modport receiver (
        input sample,
        input latch
    );

    modport readback (
        input done
    );

endinterface

// ==== rtl/controller_pkg.sv ====
package controller_pkg;

    // one bit per button, bit 0 is the first bit out of the pad (A)
    // a 1 means the button is held down
    typedef logic [7:0] buttons_t;

    localparam int BUTTON_COUNT = 8; // serial bits in one poll

    // ##################################################
    // status byte layout
    // ##################################################

    localparam int STATUS_IRQ_BIT  = 0;
    localparam int STATUS_BUSY_BIT = 1; // remaining bits read back as zero

endpackage

// ==== rtl/bus_map_pkg.sv ====
package bus_map_pkg;

    // ##################################################
    // external memories
    // ##################################################

    localparam logic [15:0] RAM_BASE = 16'h0000;
    localparam logic [15:0] RAM_LAST = 16'h3FFF;
    localparam logic [15:0] ROM_BASE = 16'h8000; // rom runs to the top of the map

    // ##################################################
    // controller registers
    // ##################################################

    localparam logic [15:0] CONTROLLER_BASE = 16'h4100; // controller n sits at base + n
    localparam logic [15:0] STATUS_ADDR     = 16'h4110;
    localparam logic [15:0] FETCH_ADDR      = 16'h4111;
    localparam logic [15:0] IRQ_CLEAR_ADDR  = 16'h4112;

    typedef struct packed {
        logic       ram;
        logic       rom;
        logic       controller;
        logic [3:0] controller_index;
        logic       status;
        logic       fetch;
        logic       irq_clear;
    } bus_select_t;

endpackage
